/* build.f */
design/tile_pkg.sv
design/tile_bus_decoder.sv
design/tile_data_mem.sv
design/tile_boot_rom.sv
design/tile_noc_mailbox.sv
design/compute_tile.sv
verif/tile_checker.sv
verif/tile_tb.sv

/* Bender.yml */
package:
  name: compute_tile

sources:
  - design/tile_pkg.sv
  - design/tile_bus_decoder.sv
  - design/tile_data_mem.sv
  - design/tile_boot_rom.sv
  - design/tile_noc_mailbox.sv
  - design/compute_tile.sv
  - target: simulation
    files:
      - verif/tile_checker.sv
      - verif/tile_tb.sv

/* verif/tile_tb.sv */
`default_nettype none

module tile_tb
  import tile_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int BUS_TIMEOUT   = 200;
  localparam int NOC_TIMEOUT   = 200;
  localparam int DRAIN_TIMEOUT = 400;
  localparam int MAX_TESTS     = 48;

  typedef enum logic [1:0] {
    OP_READ,
    OP_WRITE,
    OP_INJECT
  } op_e;

  typedef struct packed {
    logic [127:0] name;
    op_e          op;
    wb_addr_t     addr;
    wb_data_t     data;
    wb_sel_t      sel;
    logic         last;
  } test_t;

  test_t        test_table [MAX_TESTS];
  int           num_tests;
  int           timeouts;
  int           tests_run;
  int           fails;
  int           tx_pending;
  logic [31:0]  lfsr_state = 32'ha4e2729d;
  logic [127:0] test_name;

  logic      clk = 1'b0;
  logic      rst_i;
  logic      wb_cyc_i;
  logic      wb_stb_i;
  logic      wb_we_i;
  wb_addr_t  wb_adr_i;
  wb_sel_t   wb_sel_i;
  wb_data_t  wb_dat_i;
  logic      wb_ack_o;
  logic      wb_err_o;
  wb_data_t  wb_dat_o;
  noc_flit_t noc_out_flit_o;
  logic      noc_out_last_o;
  logic      noc_out_valid_o;
  logic      noc_out_ready_i = 1'b0;
  noc_flit_t noc_in_flit_i;
  logic      noc_in_last_i;
  logic      noc_in_valid_i;
  logic      noc_in_ready_o;

  always #10 clk = ~clk;

  compute_tile i_compute_tile (
    .clk             (clk),
    .rst_i           (rst_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_sel_i        (wb_sel_i),
    .wb_dat_i        (wb_dat_i),
    .wb_ack_o        (wb_ack_o),
    .wb_err_o        (wb_err_o),
    .wb_dat_o        (wb_dat_o),
    .noc_out_flit_o  (noc_out_flit_o),
    .noc_out_last_o  (noc_out_last_o),
    .noc_out_valid_o (noc_out_valid_o),
    .noc_out_ready_i (noc_out_ready_i),
    .noc_in_flit_i   (noc_in_flit_i),
    .noc_in_last_i   (noc_in_last_i),
    .noc_in_valid_i  (noc_in_valid_i),
    .noc_in_ready_o  (noc_in_ready_o)
  );

  tile_checker i_checker (
    .clk          (clk),
    .rst_i        (rst_i),
    .test_name_i  (test_name),
    .cyc_i        (wb_cyc_i),
    .stb_i        (wb_stb_i),
    .we_i         (wb_we_i),
    .adr_i        (wb_adr_i),
    .sel_i        (wb_sel_i),
    .wdata_i      (wb_dat_i),
    .ack_i        (wb_ack_o),
    .err_i        (wb_err_o),
    .rdata_i      (wb_dat_o),
    .out_flit_i   (noc_out_flit_o),
    .out_last_i   (noc_out_last_o),
    .out_valid_i  (noc_out_valid_o),
    .out_ready_i  (noc_out_ready_i),
    .in_flit_i    (noc_in_flit_i),
    .in_last_i    (noc_in_last_i),
    .in_valid_i   (noc_in_valid_i),
    .in_ready_i   (noc_in_ready_o),
    .tests_o      (tests_run),
    .fails_o      (fails),
    .tx_pending_o (tx_pending)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'h8020_0003;
    end
    return next;
  endfunction

  // Random sink readiness, one LFSR step per bit
  always @(posedge clk) begin
    lfsr_state = lfsr_next(lfsr_state);
    noc_out_ready_i <= lfsr_state[0];
  end

  task automatic add_test(input logic [127:0] name, input op_e op, input wb_addr_t addr,
                          input wb_data_t data, input wb_sel_t sel, input logic last);
    test_table[num_tests] = {name, op, addr, data, sel, last};
    num_tests++;
  endtask

  task automatic bus_access(input test_t t);
    int waited;
    test_name <= t.name;
    wb_cyc_i  <= 1'b1;
    wb_stb_i  <= 1'b1;
    wb_we_i   <= (t.op == OP_WRITE);
    wb_adr_i  <= t.addr;
    wb_sel_i  <= t.sel;
    wb_dat_i  <= t.data;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!wb_ack_o && !wb_err_o && waited < BUS_TIMEOUT);
    if (!wb_ack_o && !wb_err_o) begin
      $display("timeout: %0s got neither ack nor err within %0d cycles", t.name, BUS_TIMEOUT);
      timeouts++;
    end
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    @(posedge clk);
  endtask

  task automatic noc_inject(input test_t t);
    int waited;
    test_name      <= t.name;
    noc_in_flit_i  <= t.data;
    noc_in_last_i  <= t.last;
    noc_in_valid_i <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!noc_in_ready_o && waited < NOC_TIMEOUT);
    if (!noc_in_ready_o) begin
      $display("timeout: %0s was never accepted on noc_in", t.name);
      timeouts++;
    end
    noc_in_valid_i <= 1'b0;
    @(posedge clk);
  endtask

  task automatic drain_tx();
    int waited;
    waited = 0;
    while ((tx_pending != 0 || noc_out_valid_o) && waited < DRAIN_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (tx_pending != 0 || noc_out_valid_o) begin
      $display("timeout: %0d transmit flits never left noc_out", tx_pending);
      timeouts++;
    end
  endtask

  task automatic build_table();
    add_test("mem_wr_w0",        OP_WRITE,  32'h0000_0000, 32'h1122_3344, 4'hf, 1'b0);
    add_test("mem_wr_w1",        OP_WRITE,  32'h0000_0004, 32'hcafe_f00d, 4'hf, 1'b0);
    add_test("mem_wr_top",       OP_WRITE,  32'h0000_03fc, 32'h0bad_beef, 4'hf, 1'b0);
    add_test("mem_rd_w0",        OP_READ,   32'h0000_0000, 32'h0,         4'hf, 1'b0);
    add_test("mem_rd_w1",        OP_READ,   32'h0000_0004, 32'h0,         4'hf, 1'b0);
    add_test("mem_rd_top",       OP_READ,   32'h0000_03fc, 32'h0,         4'hf, 1'b0);
    add_test("mem_wr_byte0",     OP_WRITE,  32'h0000_0004, 32'haaaa_aaaa, 4'h1, 1'b0);
    add_test("mem_wr_mid",       OP_WRITE,  32'h0000_0004, 32'h5566_7788, 4'h6, 1'b0);
    add_test("mem_rd_partial",   OP_READ,   32'h0000_0004, 32'h0,         4'hf, 1'b0);
    add_test("mem_wr_hi_byte",   OP_WRITE,  32'h0000_0000, 32'hff00_0000, 4'h8, 1'b0);
    add_test("mem_rd_w0_again",  OP_READ,   32'h0000_0000, 32'h0,         4'hf, 1'b0);
    // Bits above 9 alias onto word 2
    add_test("mem_alias_wr",     OP_WRITE,  32'h0000_1408, 32'h600d_cafe, 4'hf, 1'b0);
    add_test("mem_alias_rd",     OP_READ,   32'h0000_0008, 32'h0,         4'hf, 1'b0);
    add_test("mem_alias_rd2",    OP_READ,   32'h0000_2c08, 32'h0,         4'hf, 1'b0);
    add_test("rom_rd_0",         OP_READ,   32'hf000_0000, 32'h0,         4'hf, 1'b0);
    add_test("rom_rd_5",         OP_READ,   32'hf000_0014, 32'h0,         4'hf, 1'b0);
    add_test("rom_rd_15",        OP_READ,   32'hf000_003c, 32'h0,         4'hf, 1'b0);
    add_test("rom_rd_alias",     OP_READ,   32'hf000_0104, 32'h0,         4'hf, 1'b0);
    add_test("rom_wr",           OP_WRITE,  32'hf000_0014, 32'hdead_beef, 4'hf, 1'b0);
    add_test("rom_rd_5_after",   OP_READ,   32'hf000_0014, 32'h0,         4'hf, 1'b0);
    add_test("unmapped_5_rd",    OP_READ,   32'h5000_0000, 32'h0,         4'hf, 1'b0);
    add_test("unmapped_5_wr",    OP_WRITE,  32'h5000_0000, 32'h1234_5678, 4'hf, 1'b0);
    add_test("unmapped_a_rd",    OP_READ,   32'ha000_0010, 32'h0,         4'hf, 1'b0);
    add_test("unmapped_a_wr",    OP_WRITE,  32'ha000_0010, 32'h8765_4321, 4'hf, 1'b0);
    add_test("mbox_status_idle", OP_READ,   32'he000_000c, 32'h0,         4'hf, 1'b0);
    add_test("tx_data_0",        OP_WRITE,  32'he000_0000, 32'h0000_0101, 4'hf, 1'b0);
    add_test("tx_status",        OP_READ,   32'he000_000c, 32'h0,         4'hf, 1'b0);
    // Back to back, later ones stall on a busy transmit register
    add_test("tx_b2b_1",         OP_WRITE,  32'he000_0000, 32'h0000_0202, 4'hf, 1'b0);
    add_test("tx_b2b_2",         OP_WRITE,  32'he000_0000, 32'h0000_0303, 4'hf, 1'b0);
    add_test("tx_b2b_3",         OP_WRITE,  32'he000_0000, 32'h0000_0404, 4'hf, 1'b0);
    add_test("tx_last_4",        OP_WRITE,  32'he000_0004, 32'h0000_0505, 4'hf, 1'b0);
    add_test("rx_inject_1",      OP_INJECT, 32'h0,         32'h1234_5678, 4'hf, 1'b1);
    add_test("rx_status_full",   OP_READ,   32'he000_000c, 32'h0,         4'hf, 1'b0);
    add_test("rx_read_1",        OP_READ,   32'he000_0008, 32'h0,         4'hf, 1'b0);
    add_test("rx_read_empty",    OP_READ,   32'he000_0008, 32'h0,         4'hf, 1'b0);
    add_test("rx_inject_2",      OP_INJECT, 32'h0,         32'h9abc_def0, 4'hf, 1'b0);
    add_test("rx_status_2",      OP_READ,   32'he000_000c, 32'h0,         4'hf, 1'b0);
    add_test("rx_read_2",        OP_READ,   32'he000_0008, 32'h0,         4'hf, 1'b0);
    add_test("status_write",     OP_WRITE,  32'he000_000c, 32'hffff_ffff, 4'hf, 1'b0);
    add_test("mbox_status_end",  OP_READ,   32'he000_000c, 32'h0,         4'hf, 1'b0);
  endtask

  initial begin
    rst_i          = 1'b1;
    wb_cyc_i       = 1'b0;
    wb_stb_i       = 1'b0;
    wb_we_i        = 1'b0;
    wb_adr_i       = '0;
    wb_sel_i       = '0;
    wb_dat_i       = '0;
    noc_in_flit_i  = '0;
    noc_in_last_i  = 1'b0;
    noc_in_valid_i = 1'b0;
    test_name      = '0;
    num_tests      = 0;
    timeouts       = 0;
    build_table();
    repeat (4) @(posedge clk);
    rst_i <= 1'b0;
    repeat (2) @(posedge clk);
    for (int i = 0; i < num_tests; i++) begin
      if (test_table[i].op == OP_INJECT) begin
        noc_inject(test_table[i]);
      end else begin
        bus_access(test_table[i]);
      end
    end
    drain_tx();
    repeat (2) @(posedge clk);
    $display("tests %0d, failed %0d, timeouts %0d", tests_run, fails, timeouts);
    if (fails == 0 && timeouts == 0 && tests_run > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/tile_checker.sv */
`default_nettype none

module tile_checker
  import tile_pkg::*;
(
  input  wire logic         clk,
  input  wire logic         rst_i,
  input  wire logic [127:0] test_name_i,
  input  wire logic         cyc_i,
  input  wire logic         stb_i,
  input  wire logic         we_i,
  input  wire wb_addr_t     adr_i,
  input  wire wb_sel_t      sel_i,
  input  wire wb_data_t     wdata_i,
  input  wire logic         ack_i,
  input  wire logic         err_i,
  input  wire wb_data_t     rdata_i,
  input  wire noc_flit_t    out_flit_i,
  input  wire logic         out_last_i,
  input  wire logic         out_valid_i,
  input  wire logic         out_ready_i,
  input  wire noc_flit_t    in_flit_i,
  input  wire logic         in_last_i,
  input  wire logic         in_valid_i,
  input  wire logic         in_ready_i,
  output int                tests_o,
  output int                fails_o,
  output int                tx_pending_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Byte image of the data memory
  logic [7:0]   mem_model [DMEM_WORDS*4];
  logic [127:0] req_name;
  logic [127:0] inj_name;
  logic         pending = 1'b0;
  logic         exp_err;
  logic         exp_cmp;
  logic         exp_tx;
  logic         exp_rx_pop;
  wb_data_t     exp_data;
  noc_flit_t    pend_flit;
  logic         pend_last;
  noc_flit_t    txq_flit [$];
  logic         txq_last [$];
  logic [127:0] txq_name [$];
  logic         rx_valid = 1'b0;
  logic         rx_last = 1'b0;
  noc_flit_t    rx_flit;
  logic         inj_check = 1'b0;
  logic         in_reset = 1'b0;
  logic         reset_checked = 1'b0;
  int           tests = 0;
  int           fails = 0;

  initial begin
    tests_o      = 0;
    fails_o      = 0;
    tx_pending_o = 0;
  end

  function automatic wb_data_t model_word(input logic [7:0] idx);
    int base;
    base = idx * 4;
    return {mem_model[base+3], mem_model[base+2], mem_model[base+1], mem_model[base]};
  endfunction

  task automatic pass_line(input logic [127:0] name);
    tests++;
    $display("ok       %0s", name);
  endtask

  task automatic value_line(input logic [127:0] name, input wb_data_t expected,
                            input wb_data_t actual);
    tests++;
    fails++;
    $display("mismatch %0s: expected %h, actual %h", name, expected, actual);
  endtask

  task automatic flag_line(input logic [127:0] name, input string what, input logic expected,
                           input logic actual);
    tests++;
    fails++;
    $display("mismatch %0s %0s: expected %b, actual %b", name, what, expected, actual);
  endtask

  task automatic fail_line(input logic [127:0] name, input string what);
    tests++;
    fails++;
    $display("error    %0s: %0s", name, what);
  endtask

  task automatic predict_mbox();
    case (adr_i[3:2])
      MBOX_TX_DATA, MBOX_TX_LAST: begin
        exp_tx    = we_i;
        pend_flit = wdata_i;
        pend_last = (adr_i[3:2] == MBOX_TX_LAST);
      end
      MBOX_RX_DATA: begin
        if (!we_i && rx_valid) begin
          exp_cmp    = 1'b1;
          exp_data   = rx_flit;
          exp_rx_pop = 1'b1;
          rx_valid   = 1'b0;
          rx_last    = 1'b0;
        end else if (!we_i) begin
          exp_err = 1'b1;
        end
      end
      default: begin
        // Status word
        if (!we_i) begin
          exp_cmp                   = 1'b1;
          exp_data[STATUS_RX_VALID] = rx_valid;
          exp_data[STATUS_RX_LAST]  = rx_last;
          exp_data[STATUS_TX_BUSY]  = (txq_flit.size() != 0);
        end
      end
    endcase
  endtask

  task automatic predict();
    logic [7:0] idx;
    req_name   = test_name_i;
    exp_err    = 1'b0;
    exp_cmp    = 1'b0;
    exp_tx     = 1'b0;
    exp_rx_pop = 1'b0;
    exp_data   = '0;
    idx        = adr_i[9:2];
    case (adr_i[REGION_MSB:REGION_LSB])
      REGION_MEM: begin
        if (we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (sel_i[b]) begin
              mem_model[idx*4 + b] = wdata_i[b*8 +: 8];
            end
          end
        end else begin
          exp_cmp  = 1'b1;
          exp_data = model_word(idx);
        end
      end
      REGION_ROM: begin
        exp_err  = we_i;
        exp_cmp  = !we_i;
        exp_data = {BOOTROM_TAG, 12'h000, adr_i[5:2]};
      end
      REGION_MBOX: predict_mbox();
      default: exp_err = 1'b1;
    endcase
  endtask

  task automatic check_response();
    if (ack_i && err_i) begin
      fail_line(req_name, "ack and err high in the same cycle");
    end else if (exp_err && ack_i) begin
      fail_line(req_name, "acknowledged where an error response was expected");
    end else if (exp_err) begin
      pass_line(req_name);
    end else if (err_i) begin
      fail_line(req_name, "unexpected error response");
    end else if (exp_tx) begin
      // Reported when the flit leaves on noc_out
      txq_flit.push_back(pend_flit);
      txq_last.push_back(pend_last);
      txq_name.push_back(req_name);
    end else if (exp_cmp && rdata_i !== exp_data) begin
      value_line(req_name, exp_data, rdata_i);
    end else if (exp_rx_pop && in_ready_i !== 1'b1) begin
      flag_line(req_name, "noc_in_ready_o", 1'b1, in_ready_i);
    end else begin
      pass_line(req_name);
    end
  endtask

  task automatic check_flit();
    logic [127:0] name;
    noc_flit_t    flit;
    logic         last;
    if (txq_flit.size() == 0) begin
      fail_line("noc_out", "flit sent on noc_out with no transmit write pending");
    end else begin
      name = txq_name.pop_front();
      flit = txq_flit.pop_front();
      last = txq_last.pop_front();
      if (out_flit_i !== flit) begin
        value_line(name, flit, out_flit_i);
      end else if (out_last_i !== last) begin
        flag_line(name, "noc_out_last_o", last, out_last_i);
      end else begin
        pass_line(name);
      end
    end
  endtask

  task automatic check_reset_values();
    if (ack_i !== 1'b0) begin
      flag_line("reset_values", "wb_ack_o", 1'b0, ack_i);
    end else if (err_i !== 1'b0) begin
      flag_line("reset_values", "wb_err_o", 1'b0, err_i);
    end else if (out_valid_i !== 1'b0) begin
      flag_line("reset_values", "noc_out_valid_o", 1'b0, out_valid_i);
    end else if (in_ready_i !== 1'b1) begin
      flag_line("reset_values", "noc_in_ready_o", 1'b1, in_ready_i);
    end else begin
      pass_line("reset_values");
    end
  endtask

  always @(posedge clk) begin
    if (rst_i) begin
      in_reset  = 1'b1;
      pending   = 1'b0;
      inj_check = 1'b0;
      rx_valid  = 1'b0;
      rx_last   = 1'b0;
      txq_flit.delete();
      txq_last.delete();
      txq_name.delete();
    end else begin
      if (in_reset && !reset_checked) begin
        reset_checked = 1'b1;
        check_reset_values();
      end
      if (pending && (ack_i || err_i)) begin
        pending = 1'b0;
        check_response();
      end else if (pending && !(cyc_i && stb_i)) begin
        pending = 1'b0;
      end else if (!pending && (ack_i || err_i)) begin
        fail_line("bus", "ack or err with no access in progress");
      end else if (!pending && cyc_i && stb_i) begin
        pending = 1'b1;
        predict();
      end
      if (out_valid_i && out_ready_i) begin
        check_flit();
      end
      if (inj_check) begin
        inj_check = 1'b0;
        if (in_ready_i !== 1'b0) begin
          flag_line(inj_name, "noc_in_ready_o", 1'b0, in_ready_i);
        end else begin
          pass_line(inj_name);
        end
      end
      if (in_valid_i && in_ready_i) begin
        rx_valid  = 1'b1;
        rx_flit   = in_flit_i;
        rx_last   = in_last_i;
        inj_name  = test_name_i;
        inj_check = 1'b1;
      end
    end
    tests_o      <= tests;
    fails_o      <= fails;
    tx_pending_o <= txq_flit.size();
  end

endmodule

`default_nettype wire

/* design/compute_tile.sv */
`default_nettype none

module compute_tile
  import tile_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_i,
  input  wire logic      wb_cyc_i,
  input  wire logic      wb_stb_i,
  input  wire logic      wb_we_i,
  input  wire wb_addr_t  wb_adr_i,
  input  wire wb_sel_t   wb_sel_i,
  input  wire wb_data_t  wb_dat_i,
  output logic           wb_ack_o,
  output logic           wb_err_o,
  output wb_data_t       wb_dat_o,
  output noc_flit_t      noc_out_flit_o,
  output logic           noc_out_last_o,
  output logic           noc_out_valid_o,
  input  wire logic      noc_out_ready_i,
  input  wire noc_flit_t noc_in_flit_i,
  input  wire logic      noc_in_last_i,
  input  wire logic      noc_in_valid_i,
  output logic           noc_in_ready_o
);

  logic     mem_stb;
  logic     mem_ack;
  wb_data_t mem_rdata;
  logic     rom_stb;
  logic     rom_ack;
  logic     rom_err;
  wb_data_t rom_rdata;
  logic     mbox_stb;
  logic     mbox_ack;
  logic     mbox_err;
  wb_data_t mbox_rdata;

  tile_bus_decoder i_bus_decoder (
    .clk          (clk),
    .rst_i        (rst_i),
    .cyc_i        (wb_cyc_i),
    .stb_i        (wb_stb_i),
    .adr_i        (wb_adr_i),
    .mem_stb_o    (mem_stb),
    .rom_stb_o    (rom_stb),
    .mbox_stb_o   (mbox_stb),
    .mem_ack_i    (mem_ack),
    // Data memory never errs
    .mem_err_i    (1'b0),
    .mem_rdata_i  (mem_rdata),
    .rom_ack_i    (rom_ack),
    .rom_err_i    (rom_err),
    .rom_rdata_i  (rom_rdata),
    .mbox_ack_i   (mbox_ack),
    .mbox_err_i   (mbox_err),
    .mbox_rdata_i (mbox_rdata),
    .ack_o        (wb_ack_o),
    .err_o        (wb_err_o),
    .rdata_o      (wb_dat_o)
  );

  tile_data_mem i_data_mem (
    .clk     (clk),
    .stb_i   (mem_stb),
    .we_i    (wb_we_i),
    .adr_i   (wb_adr_i),
    .sel_i   (wb_sel_i),
    .wdata_i (wb_dat_i),
    .ack_o   (mem_ack),
    .rdata_o (mem_rdata)
  );

  tile_boot_rom i_boot_rom (
    .clk     (clk),
    .stb_i   (rom_stb),
    .we_i    (wb_we_i),
    .adr_i   (wb_adr_i),
    .ack_o   (rom_ack),
    .err_o   (rom_err),
    .rdata_o (rom_rdata)
  );

  tile_noc_mailbox i_noc_mailbox (
    .clk             (clk),
    .rst_i           (rst_i),
    .stb_i           (mbox_stb),
    .we_i            (wb_we_i),
    .adr_i           (wb_adr_i),
    .wdata_i         (wb_dat_i),
    .ack_o           (mbox_ack),
    .err_o           (mbox_err),
    .rdata_o         (mbox_rdata),
    .noc_out_flit_o  (noc_out_flit_o),
    .noc_out_last_o  (noc_out_last_o),
    .noc_out_valid_o (noc_out_valid_o),
    .noc_out_ready_i (noc_out_ready_i),
    .noc_in_flit_i   (noc_in_flit_i),
    .noc_in_last_i   (noc_in_last_i),
    .noc_in_valid_i  (noc_in_valid_i),
    .noc_in_ready_o  (noc_in_ready_o)
  );

endmodule

`default_nettype wire

/* design/tile_noc_mailbox.sv */
`default_nettype none

module tile_noc_mailbox
  import tile_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_i,
  input  wire logic      stb_i,
  input  wire logic      we_i,
  input  wire wb_addr_t  adr_i,
  input  wire wb_data_t  wdata_i,
  output logic           ack_o,
  output logic           err_o,
  output wb_data_t       rdata_o,
  output noc_flit_t      noc_out_flit_o,
  output logic           noc_out_last_o,
  output logic           noc_out_valid_o,
  input  wire logic      noc_out_ready_i,
  input  wire noc_flit_t noc_in_flit_i,
  input  wire logic      noc_in_last_i,
  input  wire logic      noc_in_valid_i,
  output logic           noc_in_ready_o
);

  mbox_offset_t offset;
  logic         req;
  logic         tx_write;
  logic         tx_free;
  logic         tx_load;
  logic         rx_take;
  logic         rx_pop;
  logic         rx_miss;
  logic         ack_q;
  logic         err_q;
  wb_data_t     rdata_q;
  wb_data_t     rd_word;
  noc_flit_t    tx_flit_q;
  logic         tx_last_q;
  logic         tx_valid_q;
  noc_flit_t    rx_flit_q;
  logic         rx_last_q;
  logic         rx_valid_q;

  assign offset = adr_i[3:2];
  assign req    = stb_i && !ack_q && !err_q;

  // A pending flit may be replaced in the cycle it leaves
  assign tx_free  = !tx_valid_q || noc_out_ready_i;
  assign tx_write = we_i && (offset == MBOX_TX_DATA || offset == MBOX_TX_LAST);
  assign tx_load  = req && tx_write && tx_free;

  assign rx_take = noc_in_valid_i && !rx_valid_q;
  assign rx_pop  = req && !we_i && (offset == MBOX_RX_DATA) && rx_valid_q;
  assign rx_miss = req && !we_i && (offset == MBOX_RX_DATA) && !rx_valid_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q      <= 1'b0;
      err_q      <= 1'b0;
      tx_valid_q <= 1'b0;
      rx_valid_q <= 1'b0;
    end else begin
      // Tx writes wait here while the flit register is busy
      ack_q <= tx_load || (req && !tx_write && !rx_miss);
      err_q <= rx_miss;
      if (tx_load) begin
        tx_valid_q <= 1'b1;
      end else if (tx_valid_q && noc_out_ready_i) begin
        tx_valid_q <= 1'b0;
      end
      if (rx_take) begin
        rx_valid_q <= 1'b1;
      end else if (rx_pop) begin
        rx_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tx_load) begin
      tx_flit_q <= wdata_i;
      tx_last_q <= (offset == MBOX_TX_LAST);
    end
    if (rx_take) begin
      rx_flit_q <= noc_in_flit_i;
      rx_last_q <= noc_in_last_i;
    end
    if (req && !we_i) begin
      rdata_q <= rd_word;
    end
  end

  always_comb begin
    rd_word = '0;
    case (offset)
      MBOX_TX_DATA, MBOX_TX_LAST: rd_word = tx_flit_q;
      MBOX_RX_DATA:               rd_word = rx_flit_q;
      default: begin
        rd_word[STATUS_RX_VALID] = rx_valid_q;
        rd_word[STATUS_RX_LAST]  = rx_valid_q && rx_last_q;
        rd_word[STATUS_TX_BUSY]  = tx_valid_q;
      end
    endcase
  end

  assign ack_o   = ack_q;
  assign err_o   = err_q;
  assign rdata_o = rdata_q;

  assign noc_out_flit_o  = tx_flit_q;
  assign noc_out_last_o  = tx_last_q;
  assign noc_out_valid_o = tx_valid_q;
  assign noc_in_ready_o  = !rx_valid_q;

endmodule

`default_nettype wire

/* design/tile_boot_rom.sv */
`default_nettype none

module tile_boot_rom
  import tile_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     stb_i,
  input  wire logic     we_i,
  input  wire wb_addr_t adr_i,
  output logic          ack_o,
  output logic          err_o,
  output wb_data_t      rdata_o
);

  wb_data_t              rom_table [BOOTROM_WORDS];
  logic [BOOTROM_AW-1:0] rom_idx;
  logic                  access;
  logic                  ack_q;
  logic                  err_q;
  wb_data_t              rdata_q;

  for (genvar i = 0; i < BOOTROM_WORDS; i++) begin : gen_table
    assign rom_table[i] = bootrom_word(i);
  end

  assign rom_idx = adr_i[BOOTROM_AW+1:2];
  assign access  = stb_i && !ack_q && !err_q;

  // Writes are refused
  always_ff @(posedge clk) begin
    ack_q <= access && !we_i;
    err_q <= access && we_i;
  end

  always_ff @(posedge clk) begin
    if (access && !we_i) begin
      rdata_q <= rom_table[rom_idx];
    end
  end

  assign ack_o   = ack_q;
  assign err_o   = err_q;
  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* design/tile_data_mem.sv */
`default_nettype none

module tile_data_mem
  import tile_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     stb_i,
  input  wire logic     we_i,
  input  wire wb_addr_t adr_i,
  input  wire wb_sel_t  sel_i,
  input  wire wb_data_t wdata_i,
  output logic          ack_o,
  output wb_data_t      rdata_o
);

  wb_data_t             mem [DMEM_WORDS];
  logic [DMEM_AW-1:0]   word_idx;
  logic                 access;
  logic                 ack_q;
  wb_data_t             rdata_q;

  // Byte address to word index, upper bits alias
  assign word_idx = adr_i[DMEM_AW+1:2];

  // Only the first cycle of stb counts as an access
  assign access = stb_i && !ack_q;

  always_ff @(posedge clk) begin
    ack_q <= access;
  end

  always_ff @(posedge clk) begin
    if (access && we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (sel_i[b]) begin
          mem[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access && !we_i) begin
      rdata_q <= mem[word_idx];
    end
  end

  assign ack_o   = ack_q;
  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* design/tile_bus_decoder.sv */
`default_nettype none

module tile_bus_decoder
  import tile_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_i,
  input  wire logic     cyc_i,
  input  wire logic     stb_i,
  input  wire wb_addr_t adr_i,
  output logic          mem_stb_o,
  output logic          rom_stb_o,
  output logic          mbox_stb_o,
  input  wire logic     mem_ack_i,
  input  wire logic     mem_err_i,
  input  wire wb_data_t mem_rdata_i,
  input  wire logic     rom_ack_i,
  input  wire logic     rom_err_i,
  input  wire wb_data_t rom_rdata_i,
  input  wire logic     mbox_ack_i,
  input  wire logic     mbox_err_i,
  input  wire wb_data_t mbox_rdata_i,
  output logic          ack_o,
  output logic          err_o,
  output wb_data_t      rdata_o
);

  slave_e slave_sel;
  logic   req;
  logic   none_err_q;

  assign req = cyc_i && stb_i;

  always_comb begin
    case (adr_i[REGION_MSB:REGION_LSB])
      REGION_MEM:  slave_sel = SLV_MEM;
      REGION_ROM:  slave_sel = SLV_ROM;
      REGION_MBOX: slave_sel = SLV_MBOX;
      default:     slave_sel = SLV_NONE;
    endcase
  end

  assign mem_stb_o  = req && (slave_sel == SLV_MEM);
  assign rom_stb_o  = req && (slave_sel == SLV_ROM);
  assign mbox_stb_o = req && (slave_sel == SLV_MBOX);

  // Error response for an unmapped region, one pulse per access
  always_ff @(posedge clk) begin
    if (rst_i) begin
      none_err_q <= 1'b0;
    end else begin
      none_err_q <= req && (slave_sel == SLV_NONE) && !none_err_q;
    end
  end

  always_comb begin
    case (slave_sel)
      SLV_MEM: begin
        ack_o   = mem_ack_i;
        err_o   = mem_err_i;
        rdata_o = mem_rdata_i;
      end
      SLV_ROM: begin
        ack_o   = rom_ack_i;
        err_o   = rom_err_i;
        rdata_o = rom_rdata_i;
      end
      SLV_MBOX: begin
        ack_o   = mbox_ack_i;
        err_o   = mbox_err_i;
        rdata_o = mbox_rdata_i;
      end
      default: begin
        ack_o   = 1'b0;
        err_o   = none_err_q;
        rdata_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/tile_pkg.sv */
`default_nettype none

package tile_pkg;

  typedef logic [31:0] wb_addr_t;
  typedef logic [31:0] wb_data_t;
  typedef logic [3:0]  wb_sel_t;
  typedef logic [31:0] noc_flit_t;
  typedef logic [1:0]  mbox_offset_t;

  typedef enum logic [1:0] {
    SLV_MEM,
    SLV_ROM,
    SLV_MBOX,
    SLV_NONE
  } slave_e;

  // Region is the top nibble of the byte address
  localparam int REGION_MSB = 31;
  localparam int REGION_LSB = 28;

  localparam logic [3:0] REGION_MEM  = 4'h0;
  localparam logic [3:0] REGION_MBOX = 4'he;
  localparam logic [3:0] REGION_ROM  = 4'hf;

  // 1 KiB local data memory
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_AW    = 8;

  localparam int          BOOTROM_WORDS = 16;
  localparam int          BOOTROM_AW    = 4;
  localparam logic [15:0] BOOTROM_TAG   = 16'hb007;

  localparam mbox_offset_t MBOX_TX_DATA = 2'd0;
  localparam mbox_offset_t MBOX_TX_LAST = 2'd1;
  localparam mbox_offset_t MBOX_RX_DATA = 2'd2;
  localparam mbox_offset_t MBOX_STATUS  = 2'd3;

  localparam int STATUS_RX_VALID = 0;
  localparam int STATUS_RX_LAST  = 1;
  localparam int STATUS_TX_BUSY  = 2;

  // Boot ROM word: tag in the upper half, index in the lower half
  function automatic wb_data_t bootrom_word(int unsigned idx);
    wb_data_t word;
    word = {BOOTROM_TAG, 16'(idx)};
    return word;
  endfunction

endpackage

`default_nettype wire
